//--- Bender.yml
package:
  name: soc_host_mem

sources:
  - logic/soc_pkg.sv
  - logic/l2_bank.sv
  - logic/host_mailbox.sv
  - logic/host_tlb.sv
  - logic/host_decoder.sv
  - logic/soc_top.sv
  - target: test
    files:
      - test/soc_top_properties.sv
      - test/tb_soc_top.sv

//--- logic/host_decoder.sv
// host port region decoder, routes each Wishbone access and merges the target answers
`timescale 1ns/1ns

module host_decoder import soc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // host side
  input  wb_req_t               wb_req_i,
  output wb_rsp_t               wb_rsp_o,
  // translation table, memory and config regions
  output wb_req_t               tlb_req_o,
  output logic                  tlb_cfg_o,
  input  wb_rsp_t               tlb_rsp_i,
  // mailbox region
  output wb_req_t               mbox_req_o,
  input  wb_rsp_t               mbox_rsp_i,
  // bank answers for translated memory accesses
  input  l2_rsp_t [N_BANKS-1:0] bank_rsp_i
);

  host_addr_u addr;
  logic       is_mem;
  logic       is_tlb;
  logic       is_mbox;
  logic       unmapped;
  logic       unmapped_err_q;
  logic       bank_ack;

  assign addr = wb_req_i.adr;

  // region decode
  assign is_mem   = (addr.mem.region == REGION_MEM);
  assign is_tlb   = (addr.cfg.region == REGION_TLB);
  assign is_mbox  = (addr.mem.region == REGION_MBOX);
  assign unmapped = ~(is_mem | is_tlb | is_mbox);

  // the table serves both the memory and its own config region
  always_comb begin
    tlb_req_o     = wb_req_i;
    tlb_req_o.stb = wb_req_i.stb & (is_mem | is_tlb);
  end

  assign tlb_cfg_o = is_tlb;

  always_comb begin
    mbox_req_o     = wb_req_i;
    mbox_req_o.stb = wb_req_i.stb & is_mbox;
  end

  // nobody lives here, answer err one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      unmapped_err_q <= 1'b0;
    end else begin
      unmapped_err_q <= wb_req_i.cyc & wb_req_i.stb & unmapped & ~unmapped_err_q;
    end
  end

  // one ack per access, so at most one bank acks at a time
  always_comb begin
    bank_ack = 1'b0;
    for (int n = 0; n < N_BANKS; n++) begin
      bank_ack = bank_ack | bank_rsp_i[n].ack;
    end
  end

  always_comb begin
    wb_rsp_o.ack = tlb_rsp_i.ack | mbox_rsp_i.ack | bank_ack;
    wb_rsp_o.err = tlb_rsp_i.err | mbox_rsp_i.err | unmapped_err_q;
  end

  // read data from whichever target acked
  always_comb begin
    wb_rsp_o.dat = '0;
    if (tlb_rsp_i.ack) begin
      wb_rsp_o.dat = tlb_rsp_i.dat;
    end
    if (mbox_rsp_i.ack) begin
      wb_rsp_o.dat = mbox_rsp_i.dat;
    end
    for (int n = 0; n < N_BANKS; n++) begin
      if (bank_rsp_i[n].ack) begin
        wb_rsp_o.dat = bank_rsp_i[n].rdata;
      end
    end
  end

endmodule

//--- logic/host_mailbox.sv
// host mailbox FIFO, push on write and pop on read, irq while it holds data
`timescale 1ns/1ns

module host_mailbox import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o,
  output logic    irq_o
);

  logic [DATA_W-1:0]     fifo_q [MBOX_DEPTH];
  logic [MBOX_PTR_W-1:0] wr_ptr_q;
  logic [MBOX_PTR_W-1:0] rd_ptr_q;
  logic [MBOX_CNT_W-1:0] count_q;
  logic                  req_valid;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;
  logic                  ack_q;
  logic                  err_q;
  logic [DATA_W-1:0]     dat_q;

  assign req_valid = req_i.cyc & req_i.stb & ~(ack_q | err_q);
  assign full      = (count_q == MBOX_CNT_W'(MBOX_DEPTH));
  assign empty     = (count_q == '0);
  assign push      = req_valid & req_i.we & ~full;
  assign pop       = req_valid & ~req_i.we & ~empty;

  // pointers wrap naturally at depth 8
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      wr_ptr_q <= wr_ptr_q + MBOX_PTR_W'(push);
      rd_ptr_q <= rd_ptr_q + MBOX_PTR_W'(pop);
      count_q  <= count_q + MBOX_CNT_W'(push) - MBOX_CNT_W'(pop);
      ack_q    <= push | pop;
      err_q    <= req_valid & ~push & ~pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= req_i.dat;
    end
    if (pop) begin
      dat_q <= fifo_q[rd_ptr_q];
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = err_q;
  assign rsp_o.dat = dat_q;
  assign irq_o     = ~empty;

endmodule

//--- logic/host_tlb.sv
// host address translation table, configured over the host port, steering hits to the L2 banks
`timescale 1ns/1ns

module host_tlb import soc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  wb_req_t               req_i,
  input  logic                  cfg_i,
  output wb_rsp_t               rsp_o,
  output l2_req_t [N_BANKS-1:0] bank_req_o
);

  host_addr_u        addr;
  tlb_entry_t        entry_q [TLB_ENTRIES];
  logic              req_valid;
  logic              hit;
  logic [PPN_W-1:0]  hit_ppn;
  logic [BANK_SEL_W-1:0] bank_sel;
  logic [BANK_IDX_W-1:0] word_idx;
  logic              ack_q;
  logic              err_q;
  logic [DATA_W-1:0] dat_q;

  assign addr = req_i.adr;

  // no second answer while our own ack or err is up
  assign req_valid = req_i.cyc & req_i.stb & ~(ack_q | err_q);

  // parallel compare, walk downwards so the lowest index wins
  always_comb begin
    hit     = 1'b0;
    hit_ppn = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (entry_q[i].valid && entry_q[i].vpn == addr.mem.vpn) begin
        hit     = 1'b1;
        hit_ppn = entry_q[i].ppn;
      end
    end
  end

  // physical address is {ppn, offset}, bank from bits 3:2, word from 11:4
  assign bank_sel = addr.mem.offset[BANK_SEL_W+1:2];
  assign word_idx = {hit_ppn, addr.mem.offset[PAGE_OFFSET_W-1:BANK_SEL_W+2]};

  always_comb begin
    for (int n = 0; n < N_BANKS; n++) begin
      bank_req_o[n].stb   = req_valid & ~cfg_i & hit & (bank_sel == BANK_SEL_W'(n));
      bank_req_o[n].we    = req_i.we;
      bank_req_o[n].idx   = word_idx;
      bank_req_o[n].sel   = req_i.sel;
      bank_req_o[n].wdata = req_i.dat;
    end
  end

  // config writes, byte selects ignored
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        entry_q[i] <= '0;
      end
    end else if (req_valid && cfg_i && req_i.we) begin
      entry_q[addr.cfg.idx] <= tlb_entry_t'(req_i.dat[TLB_ENTRY_W-1:0]);
    end
  end

  // config ack and miss err, one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_valid & cfg_i;
      err_q <= req_valid & ~cfg_i & ~hit;
    end
  end

  // entry read back, zero extended
  always_ff @(posedge clk_i) begin
    if (req_valid && cfg_i) begin
      dat_q <= DATA_W'(entry_q[addr.cfg.idx]);
    end
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = err_q;
    rsp_o.dat = dat_q;
  end

endmodule

//--- logic/l2_bank.sv
// single L2 bank, byte-select writes with registered read data and ack
`timescale 1ns/1ns

module l2_bank import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  l2_req_t req_i,
  output l2_rsp_t rsp_o
);

  logic [DATA_W-1:0] mem_q [BANK_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;
  logic              access;

  // ignore the request in the cycle we already answer it
  assign access = req_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (req_i.we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (req_i.sel[b]) begin
            mem_q[req_i.idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= mem_q[req_i.idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- logic/soc_pkg.sv
// shared address map, widths and bus types, imported by every module of the host memory side
package soc_pkg;

  // host port
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned SEL_W  = 4;

  // address regions, top nibble of the host address
  localparam int unsigned REGION_W = 4;
  localparam logic [REGION_W-1:0] REGION_MEM  = 4'd0;
  localparam logic [REGION_W-1:0] REGION_TLB  = 4'd1;
  localparam logic [REGION_W-1:0] REGION_MBOX = 4'd2;

  // translation, 1 KiB pages
  localparam int unsigned PAGE_OFFSET_W = 10;
  localparam int unsigned VPN_W         = 18;
  localparam int unsigned PPN_W         = 2;
  localparam int unsigned TLB_ENTRIES   = 4;
  localparam int unsigned TLB_IDX_W     = 2;

  // L2, word interleaved over the banks
  localparam int unsigned N_BANKS    = 4;
  localparam int unsigned BANK_SEL_W = 2;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_IDX_W = 8;

  // host mailbox
  localparam int unsigned MBOX_DEPTH = 8;
  localparam int unsigned MBOX_PTR_W = 3;
  localparam int unsigned MBOX_CNT_W = 4;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                  stb;
    logic                  we;
    logic [BANK_IDX_W-1:0] idx;
    logic [SEL_W-1:0]      sel;
    logic [DATA_W-1:0]     wdata;
  } l2_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } l2_rsp_t;

  // stored as the low bits of a config data word
  typedef struct packed {
    logic             valid;
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] ppn;
  } tlb_entry_t;

  localparam int unsigned TLB_ENTRY_W = $bits(tlb_entry_t);

  typedef struct packed {
    logic [REGION_W-1:0]      region;
    logic [VPN_W-1:0]         vpn;
    logic [PAGE_OFFSET_W-1:0] offset;
  } host_mem_addr_t;

  typedef struct packed {
    logic [REGION_W-1:0]                  region;
    logic [ADDR_W-REGION_W-TLB_IDX_W-3:0] unused;
    logic [TLB_IDX_W-1:0]                 idx;
    logic [1:0]                           byte_ofs;
  } host_cfg_addr_t;

  typedef union packed {
    host_mem_addr_t mem;
    host_cfg_addr_t cfg;
  } host_addr_u;

endpackage

//--- logic/soc_top.sv
// top level of the host memory side, host Wishbone port in, mailbox irq out
`timescale 1ns/1ns

module soc_top import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output logic    mbox_irq_o
);

  wb_req_t               tlb_req;
  logic                  tlb_cfg;
  wb_rsp_t               tlb_rsp;
  wb_req_t               mbox_req;
  wb_rsp_t               mbox_rsp;
  l2_req_t [N_BANKS-1:0] bank_req;
  l2_rsp_t [N_BANKS-1:0] bank_rsp;

  host_decoder i_host_decoder (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .tlb_req_o  (tlb_req),
    .tlb_cfg_o  (tlb_cfg),
    .tlb_rsp_i  (tlb_rsp),
    .mbox_req_o (mbox_req),
    .mbox_rsp_i (mbox_rsp),
    .bank_rsp_i (bank_rsp)
  );

  host_tlb i_host_tlb (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (tlb_req),
    .cfg_i      (tlb_cfg),
    .rsp_o      (tlb_rsp),
    .bank_req_o (bank_req)
  );

  host_mailbox i_host_mailbox (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (mbox_req),
    .rsp_o   (mbox_rsp),
    .irq_o   (mbox_irq_o)
  );

  // word interleaved L2, 1 KiB per bank
  for (genvar n = 0; n < N_BANKS; n++) begin : gen_banks
    l2_bank i_l2_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (bank_req[n]),
      .rsp_o   (bank_rsp[n])
    );
  end

endmodule

//--- tb.f
logic/soc_pkg.sv
logic/l2_bank.sv
logic/host_mailbox.sv
logic/host_tlb.sv
logic/host_decoder.sv
logic/soc_top.sv
test/soc_top_properties.sv
test/tb_soc_top.sv

//--- test/soc_top_properties.sv
// concurrent checks on the host Wishbone port and mailbox irq, bound into soc_top
`timescale 1ns/1ns

module soc_top_properties import soc_pkg::*; (
  input logic    clk_i,
  input logic    reset_i,
  input wb_req_t wb_req_i,
  input wb_rsp_t wb_rsp_i,
  input logic    mbox_irq_i
);

  int unsigned fail_count = 0;

  ack_err_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(wb_rsp_i.ack && wb_rsp_i.err))
    else begin
      $error("ack and err high in the same cycle");
      fail_count++;
    end

  // an answer only after a cycle with an active request
  answer_after_request: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_rsp_i.ack || wb_rsp_i.err) |-> $past(wb_req_i.cyc && wb_req_i.stb))
    else begin
      $error("ack or err without a request in the previous cycle");
      fail_count++;
    end

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else begin
      $error("ack high for two cycles in a row");
      fail_count++;
    end

  // from the second reset cycle on, registers are cleared
  irq_low_in_reset: assert property (@(posedge clk_i)
    (reset_i && $past(reset_i)) |-> !mbox_irq_i)
    else begin
      $error("mailbox irq high during reset");
      fail_count++;
    end

endmodule

bind soc_top soc_top_properties props0 (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .wb_req_i   (wb_req_i),
  .wb_rsp_i   (wb_rsp_o),
  .mbox_irq_i (mbox_irq_o)
);

//--- test/tb_soc_top.sv
// testbench for soc_top, random host accesses checked against a memory, table and mailbox model
`timescale 1ns/1ns

module tb_soc_top import soc_pkg::*; ();

  logic    clk;
  logic    reset;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    mbox_irq;

  // reference model, memory keyed by 12-bit physical byte address
  logic [7:0]        mem_model [4096];
  bit                mem_written [4096];
  tlb_entry_t        tlb_model [TLB_ENTRIES];
  logic [DATA_W-1:0] mbox_model [$];

  string            test_name;
  int               tests;
  int               errors;
  int               test_errors;
  logic [VPN_W-1:0] vpn_a;
  logic [VPN_W-1:0] vpn_b;

  soc_top dut0 (
    .clk_i      (clk),
    .reset_i    (reset),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .mbox_irq_o (mbox_irq)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected) else begin
      $display("error %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests++;
    errors += test_errors;
    $display("test %s done, %0d errors", test_name, test_errors);
  endtask

  // one classic cycle, returns at a falling edge after stb was low for a cycle
  task automatic access(input logic we, input logic [ADDR_W-1:0] adr,
                        input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat,
                        output logic ack, output logic err, output logic [DATA_W-1:0] rdat);
    int waited;
    waited = 0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
    @(negedge clk);
    while (!(wb_rsp.ack || wb_rsp.err) && waited < 16) begin
      waited++;
      @(negedge clk);
    end
    if (!(wb_rsp.ack || wb_rsp.err)) begin
      $display("%s: no ack or err within 16 cycles for address %h", test_name, adr);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      ack  = wb_rsp.ack;
      err  = wb_rsp.err;
      rdat = wb_rsp.dat;
      // request held over the sampling edge must not be answered again
      @(negedge clk);
      check_value("{ack,err} after the answer", 2'b00, {wb_rsp.ack, wb_rsp.err});
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      @(negedge clk);
    end
  endtask

  // lowest valid matching entry wins, -1 on a miss
  function automatic int lookup_ppn(input logic [ADDR_W-1:0] adr);
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (tlb_model[i].valid && tlb_model[i].vpn == adr[27:10]) begin
        return tlb_model[i].ppn;
      end
    end
    return -1;
  endfunction

  function automatic logic [DATA_W-1:0] make_entry(input logic valid, input logic [VPN_W-1:0] vpn,
                                                   input logic [PPN_W-1:0] ppn);
    return DATA_W'({valid, vpn, ppn});
  endfunction

  task automatic tlb_write(input int idx, input logic [DATA_W-1:0] dat);
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] rdat;
    access(1'b1, {REGION_TLB, 24'($urandom), 2'(idx), 2'b00}, 4'($urandom), dat,
           ack, err, rdat);
    check_value("config write {ack,err}", 2'b10, {ack, err});
    tlb_model[idx] = dat[TLB_ENTRY_W-1:0];
  endtask

  task automatic tlb_read(input int idx);
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] rdat;
    access(1'b0, {REGION_TLB, 24'($urandom), 2'(idx), 2'($urandom)}, 4'($urandom), '0,
           ack, err, rdat);
    check_value("config read {ack,err}", 2'b10, {ack, err});
    check_value("config read data", DATA_W'(tlb_model[idx]), rdat);
  endtask

  task automatic mem_access(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat);
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] rdat;
    logic [DATA_W-1:0] expected;
    logic [DATA_W-1:0] mask;
    logic [11:0]       pa;
    int                ppn;
    ppn = lookup_ppn(adr);
    access(we, adr, sel, dat, ack, err, rdat);
    check_value("memory {ack,err}", (ppn >= 0) ? 2'b10 : 2'b01, {ack, err});
    expected = '0;
    mask     = '0;
    if (ppn >= 0) begin
      for (int b = 0; b < SEL_W; b++) begin
        pa = {ppn[1:0], adr[9:2], 2'(b)};
        if (we && sel[b]) begin
          mem_model[pa]   = dat[8*b +: 8];
          mem_written[pa] = 1'b1;
        end else if (!we && mem_written[pa]) begin
          expected[8*b +: 8] = mem_model[pa];
          mask[8*b +: 8]     = 8'hff;
        end
      end
      if (!we) begin
        check_value("read data", expected, rdat & mask);
      end
    end
  endtask

  // small offset range so reads often land on written bytes
  task automatic random_mem(input int n, input logic [VPN_W-1:0] vpn_x,
                            input logic [VPN_W-1:0] vpn_y);
    logic [VPN_W-1:0] vpn;
    for (int k = 0; k < n; k++) begin
      vpn = $urandom_range(1) ? vpn_x : vpn_y;
      mem_access(1'($urandom), {REGION_MEM, vpn, 4'h0, 4'($urandom_range(15)), 2'($urandom)},
                 4'($urandom), $urandom);
    end
  endtask

  task automatic mbox_access(input logic we, input logic [DATA_W-1:0] dat);
    logic              ok;
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] rdat;
    logic [DATA_W-1:0] expected;
    ok = we ? (mbox_model.size() < MBOX_DEPTH) : (mbox_model.size() > 0);
    access(we, {REGION_MBOX, 28'($urandom)}, 4'($urandom), dat, ack, err, rdat);
    check_value("mailbox {ack,err}", ok ? 2'b10 : 2'b01, {ack, err});
    if (ok && we) begin
      mbox_model.push_back(dat);
    end else if (ok) begin
      expected = mbox_model.pop_front();
      check_value("mailbox data", expected, rdat);
    end
    check_value("irq", mbox_model.size() > 0, mbox_irq);
  endtask

  initial begin
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] rdat;
    void'($urandom(32'h2ccc528d));
    clk    = 1'b0;
    reset  = 1'b1;
    wb_req = '0;
    tests  = 0;
    errors = 0;
    foreach (tlb_model[i]) begin
      tlb_model[i] = '0;
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;

    start_test("after reset");
    check_value("irq", 0, mbox_irq);
    mem_access(1'($urandom), {REGION_MEM, 28'($urandom)}, 4'hf, $urandom);
    mbox_access(1'b0, '0);
    access(1'($urandom), {4'(3 + $urandom_range(12)), 28'($urandom)}, 4'hf, $urandom,
           ack, err, rdat);
    check_value("unmapped {ack,err}", 2'b01, {ack, err});
    end_test();

    start_test("table config");
    for (int k = 0; k < 12; k++) begin
      tlb_write(k % TLB_ENTRIES, $urandom);
      tlb_read(k % TLB_ENTRIES);
    end
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      tlb_read(i);
    end
    end_test();

    // two virtual pages on ppn 1
    start_test("translated memory");
    vpn_a = 18'($urandom);
    vpn_b = vpn_a + 18'd1;
    tlb_write(0, make_entry(1'b1, vpn_a, 2'd1));
    tlb_write(1, make_entry(1'b1, vpn_b, 2'd1));
    tlb_write(2, '0);
    tlb_write(3, '0);
    random_mem(48, vpn_a, vpn_b);
    end_test();

    start_test("translation rules");
    tlb_write(3, make_entry(1'b1, vpn_a, 2'd2));
    random_mem(16, vpn_a, vpn_a);
    tlb_write(0, '0);
    random_mem(12, vpn_a, vpn_b);
    tlb_write(1, make_entry(1'b0, vpn_b, 2'd1));
    random_mem(6, vpn_b, vpn_b);
    end_test();

    start_test("mailbox");
    for (int k = 0; k < MBOX_DEPTH; k++) begin
      mbox_access(1'b1, $urandom);
    end
    check_value("irq when full", 1, mbox_irq);
    mbox_access(1'b1, $urandom);
    for (int k = 0; k <= MBOX_DEPTH; k++) begin
      mbox_access(1'b0, '0);
    end
    end_test();

    $display("%0d tests run, %0d errors, %0d property failures", tests, errors,
             dut0.props0.fail_count);
    if (errors == 0 && dut0.props0.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
